//--- compile.f
+incdir+logic
logic/lane_seq_pkg.sv
logic/lane_req_decoder.sv
logic/operand_cmd_issuer.sv
logic/vinsn_tracker.sv
logic/lane_sequencer.sv
dv/tb_lane_sequencer.sv

//--- dv/tb_lane_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Lane sequencer testbench
// Drives random ALU and MFPU requests, back-pressure and done pulses, and
// checks the DUT against a cycle model with concurrent assertions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lane_seq_consts.svh"

module tb_lane_sequencer;

  localparam int NR_RAND     = 24;
  localparam int NR_ZERO     = 8;
  localparam int REQ_CYCLES  = 12;
  localparam int MAX_CYCLES  = (4 * NR_RAND + NR_ZERO + 20) * REQ_CYCLES + 200;
  localparam int MASK_ELEMS  = `LANE_NR_LANES * `LANE_ELEN;

  logic                                      clk_i = 1'b0;
  logic                                      rst_ni;
  lane_seq_pkg::lane_id_t                    lane_id_i;
  lane_seq_pkg::pe_req_t                     pe_req_i;
  logic                                      pe_req_valid_i;
  logic                                      pe_req_ready_o;
  lane_seq_pkg::vinsn_vec_t                  pe_vinsn_running_i;
  lane_seq_pkg::pe_resp_t                    pe_resp_o;
  lane_seq_pkg::opq_cmd_t [`LANE_NR_OPQ-1:0] opq_cmd_o;
  logic                   [`LANE_NR_OPQ-1:0] opq_valid_o;
  logic                   [`LANE_NR_OPQ-1:0] opq_ready_i;
  lane_seq_pkg::vfu_op_t                     vfu_op_o;
  logic                                      vfu_op_valid_o;
  lane_seq_pkg::vinsn_vec_t                  alu_vinsn_done_i;
  lane_seq_pkg::vinsn_vec_t                  mfpu_vinsn_done_i;
  logic                                      alu_vinsn_done_o;
  logic                                      mfpu_vinsn_done_o;

  int          errors = 0;
  int          n_req = 0;
  int          cycles = 0;
  logic [31:0] lfsr = 32'h37d51f74;

  lane_sequencer lane_sequencer_i (.*);

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  logic                                      m_held_q;
  lane_seq_pkg::pe_req_t                     m_req_q;
  logic                   [`LANE_NR_OPQ-1:0] m_slot_v;
  lane_seq_pkg::opq_cmd_t [`LANE_NR_OPQ-1:0] m_slot_cmd;
  logic                                      m_vfu_v;
  lane_seq_pkg::vfu_op_t                     m_vfu_op;
  lane_seq_pkg::vinsn_vec_t                  m_running;
  lane_seq_pkg::vinsn_vec_t                  m_resp;
  logic                                      m_alu_done;
  logic                                      m_mfpu_done;

  lane_seq_pkg::pe_req_t                     cur;
  logic                                      cur_valid;
  lane_seq_pkg::vlen_t                       exp_lane_vl;
  lane_seq_pkg::vlen_t                       exp_mask_vl;
  logic                   [`LANE_NR_OPQ-1:0] need;
  logic                   [`LANE_NR_OPQ-1:0] push;
  lane_seq_pkg::opq_cmd_t [`LANE_NR_OPQ-1:0] cmd;
  logic                                      can_issue;
  logic                                      accept;
  logic                                      exp_ready;

  function automatic lane_seq_pkg::opq_cmd_t mk_cmd(lane_seq_pkg::pe_req_t r,
      lane_seq_pkg::vreg_t vs, lane_seq_pkg::sew_e eew, lane_seq_pkg::vlen_t vl,
      lane_seq_pkg::vinsn_vec_t hz);
    lane_seq_pkg::opq_cmd_t c;
    c.id = r.id;
    c.vs = vs;
    c.eew = eew;
    c.vl = vl;
    c.hazard = hz;
    return c;
  endfunction

  always_comb begin
    cur         = m_held_q ? m_req_q : pe_req_i;
    cur_valid   = m_held_q | pe_req_valid_i;
    // Round robin split, low lanes take the remainder
    exp_lane_vl = cur.vl / `LANE_NR_LANES;
    if (int'(lane_id_i) < int'(cur.vl) % `LANE_NR_LANES) exp_lane_vl = exp_lane_vl + 1;
    exp_mask_vl = lane_seq_pkg::vlen_t'((int'(cur.vl) + MASK_ELEMS - 1) / MASK_ELEMS);
    need = '0;
    push = '0;
    cmd  = '0;
    need[`LANE_OPQ_MASK_M] = 1'b1;
    cmd[`LANE_OPQ_MASK_M] = mk_cmd(cur, '0, cur.vsew, exp_mask_vl,
                                   cur.hazard_vm | cur.hazard_vd);
    push[`LANE_OPQ_MASK_M] = !cur.vm;
    if (cur.vfu == lane_seq_pkg::VFU_ALU) begin
      need[`LANE_OPQ_ALU_A] = 1'b1;
      need[`LANE_OPQ_ALU_B] = 1'b1;
      cmd[`LANE_OPQ_ALU_A] = mk_cmd(cur, cur.vs1, cur.eew_vs1, exp_lane_vl,
                                    cur.hazard_vs1 | cur.hazard_vd);
      cmd[`LANE_OPQ_ALU_B] = mk_cmd(cur, cur.vs2, cur.eew_vs2, exp_lane_vl,
                                    cur.hazard_vs2 | cur.hazard_vd);
      push[`LANE_OPQ_ALU_A] = cur.use_vs1;
      push[`LANE_OPQ_ALU_B] = cur.use_vs2;
    end else begin
      need[`LANE_OPQ_FPU_C:`LANE_OPQ_FPU_A] = 3'b111;
      cmd[`LANE_OPQ_FPU_A] = mk_cmd(cur, cur.vs1, cur.eew_vs1, exp_lane_vl,
                                    cur.hazard_vs1 | cur.hazard_vd);
      push[`LANE_OPQ_FPU_A] = cur.use_vs1;
      cmd[`LANE_OPQ_FPU_B] = cur.swap_vs2_vd_op ?
          mk_cmd(cur, cur.vd, cur.eew_vd_op, exp_lane_vl, cur.hazard_vd) :
          mk_cmd(cur, cur.vs2, cur.eew_vs2, exp_lane_vl, cur.hazard_vs2 | cur.hazard_vd);
      cmd[`LANE_OPQ_FPU_C] = cur.swap_vs2_vd_op ?
          mk_cmd(cur, cur.vs2, cur.eew_vs2, exp_lane_vl, cur.hazard_vs2 | cur.hazard_vd) :
          mk_cmd(cur, cur.vd, cur.eew_vd_op, exp_lane_vl, cur.hazard_vd);
      push[`LANE_OPQ_FPU_B] = cur.swap_vs2_vd_op ? cur.use_vd_op : cur.use_vs2;
      push[`LANE_OPQ_FPU_C] = cur.swap_vs2_vd_op ? cur.use_vs2 : cur.use_vd_op;
    end
    can_issue = ((m_slot_v & need) == '0) &&
                !(m_running[cur.id] && pe_vinsn_running_i[cur.id]);
    accept    = cur_valid && can_issue;
    exp_ready = !m_held_q || can_issue;
    if (!accept) push = '0;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_held_q    <= 1'b0;
      m_slot_v    <= '0;
      m_vfu_v     <= 1'b0;
      m_running   <= '0;
      m_resp      <= '0;
      m_alu_done  <= 1'b0;
      m_mfpu_done <= 1'b0;
    end else begin
      if (pe_req_valid_i && exp_ready && (m_held_q || !accept)) begin
        m_held_q <= 1'b1;
        m_req_q  <= pe_req_i;
      end else if (accept) begin
        m_held_q <= 1'b0;
      end
      m_slot_v <= (m_slot_v & ~opq_ready_i) | push;
      for (int q = 0; q < `LANE_NR_OPQ; q++) begin
        if (push[q]) m_slot_cmd[q] <= cmd[q];
      end
      m_vfu_v <= accept && exp_lane_vl != '0;
      if (accept) begin
        m_vfu_op <= '{id: cur.id, op: cur.op, vfu: cur.vfu, vm: cur.vm,
                      use_vs1: cur.use_vs1, use_vs2: cur.use_vs2,
                      use_vd_op: cur.use_vd_op, swap_vs2_vd_op: cur.swap_vs2_vd_op,
                      vd: cur.vd, vsew: cur.vsew, vl: exp_lane_vl};
      end
      m_running <= (m_running & pe_vinsn_running_i) |
                   ((accept && exp_lane_vl != '0) ? 8'(1) << cur.id : '0);
      m_resp <= alu_vinsn_done_i | mfpu_vinsn_done_i |
                ((accept && exp_lane_vl == '0) ? 8'(1) << cur.id : '0);
      m_alu_done  <= |alu_vinsn_done_i;
      m_mfpu_done <= |mfpu_vinsn_done_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    errors++;
    $display("[ERROR] %s expected %h actual %h", name, exp_v, act_v);
  endtask

  ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_req_ready_o == exp_ready)
    else report_mismatch("pe_req_ready", 64'(exp_ready), 64'(pe_req_ready_o));
  vfu_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      vfu_op_valid_o == m_vfu_v)
    else report_mismatch("vfu_op_valid", 64'(m_vfu_v), 64'(vfu_op_valid_o));
  vfu_op_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      m_vfu_v |-> vfu_op_o == m_vfu_op)
    else report_mismatch("vfu_op", 64'(m_vfu_op), 64'(vfu_op_o));
  opq_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      opq_valid_o == m_slot_v)
    else report_mismatch("opq_valid", 64'(m_slot_v), 64'(opq_valid_o));
  resp_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_resp_o.vinsn_done == m_resp)
    else report_mismatch("vinsn_done", 64'(m_resp), 64'(pe_resp_o));
  done_out_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      alu_vinsn_done_o == m_alu_done && mfpu_vinsn_done_o == m_mfpu_done)
    else report_mismatch("vfu_done", {m_alu_done, m_mfpu_done},
                         {alu_vinsn_done_o, mfpu_vinsn_done_o});

  for (genvar q = 0; q < `LANE_NR_OPQ; q++) begin : g_slot
    slot_cmd_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        m_slot_v[q] |-> opq_cmd_o[q] == m_slot_cmd[q])
      else report_mismatch($sformatf("opq_cmd[%0d]", q), 64'(m_slot_cmd[q]),
                           64'(opq_cmd_o[q]));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic lane_seq_pkg::pe_req_t rand_req(input lane_seq_pkg::vfu_e vfu);
    lane_seq_pkg::pe_req_t r;
    r = '0;
    r.id = rand_bits(3);
    r.op = rand_bits(6);
    r.vfu = vfu;
    {r.vm, r.use_vs1, r.use_vs2, r.use_vd_op, r.swap_vs2_vd_op} = rand_bits(5);
    {r.vs1, r.vs2, r.vd} = rand_bits(15);
    r.eew_vs1 = lane_seq_pkg::sew_e'(rand_bits(2));
    r.eew_vs2 = lane_seq_pkg::sew_e'(rand_bits(2));
    r.eew_vd_op = lane_seq_pkg::sew_e'(rand_bits(2));
    r.vsew = lane_seq_pkg::sew_e'(rand_bits(2));
    r.vl = rand_bits(11);
    {r.hazard_vs1, r.hazard_vs2, r.hazard_vd, r.hazard_vm} = rand_bits(32);
    return r;
  endfunction

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  // Holds the request until the handshake edge
  task automatic send_req(input lane_seq_pkg::pe_req_t r);
    pe_req_i = r;
    pe_req_valid_i = 1'b1;
    @(negedge clk_i);
    while (!pe_req_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #2;
    pe_req_valid_i = 1'b0;
    n_req++;
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    lane_seq_pkg::pe_req_t r;
    rst_ni = 1'b0;
    lane_id_i = '0;
    pe_req_i = '0;
    pe_req_valid_i = 1'b0;
    pe_vinsn_running_i = '0;
    opq_ready_i = '1;
    alu_vinsn_done_i = '0;
    mfpu_vinsn_done_i = '0;
    idle(10);
    rst_ni = 1'b1;
    idle(2);

    // ALU and MFPU issue with random lengths, lanes, swap and mask bits
    for (int i = 0; i < 2 * NR_RAND; i++) begin
      lane_id_i = rand_bits(2);
      send_req(rand_req(lane_seq_pkg::vfu_e'(i % 2)));
      idle(2);
    end

    // Lanes without elements
    lane_id_i = 2'd3;
    for (int i = 0; i < NR_ZERO; i++) begin
      r = rand_req(lane_seq_pkg::vfu_e'(i % 2));
      r.vl = rand_bits(1);
      send_req(r);
      idle(2);
    end

    // Slots held by a stalled operand requester
    lane_id_i = 2'd0;
    for (int i = 0; i < NR_RAND; i++) begin
      opq_ready_i = '0;
      r = rand_req(lane_seq_pkg::vfu_e'(i % 2));
      {r.vm, r.use_vs1, r.use_vs2, r.use_vd_op} = 4'b0111;
      send_req(r);
      fork
        send_req(rand_req(r.vfu));
        begin
          idle(5);
          opq_ready_i = '1;
        end
      join
      idle(2);
    end

    // Requests whose ID is still running
    idle(1);
    pe_vinsn_running_i = '1;
    for (int i = 0; i < NR_RAND; i++) begin
      r = rand_req(lane_seq_pkg::vfu_e'(i % 2));
      r.vl = 16'd64;
      send_req(r);
      fork
        send_req(r);
        begin
          idle(4);
          pe_vinsn_running_i = '0;
        end
      join
      // The last issue leaves the running set while the view is clear
      idle(2);
      pe_vinsn_running_i = '1;
    end
    pe_vinsn_running_i = '0;

    // Done pulses from the VFUs
    for (int i = 0; i < NR_RAND; i++) begin
      alu_vinsn_done_i = rand_bits(8);
      mfpu_vinsn_done_i = rand_bits(8);
      idle(1);
      alu_vinsn_done_i = '0;
      mfpu_vinsn_done_i = '0;
      idle(1);
    end

    idle(4);
    $display("Summary: %0d requests, %0d cycles, %0d errors", n_req, cycles, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/lane_req_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Lane request decoder
// Holds one request from the main sequencer in a fall-through register
// and works out how many elements and mask words fall into this lane
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lane_seq_consts.svh"

module lane_req_decoder (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lane_seq_pkg::lane_id_t  lane_id_i,
  input  lane_seq_pkg::pe_req_t   pe_req_i,
  input  logic                    pe_req_valid_i,
  output logic                    pe_req_ready_o,
  output lane_seq_pkg::lane_req_t lane_req_o,
  output logic                    req_valid_o,
  input  logic                    req_ready_i
);

  lane_seq_pkg::pe_req_t req_q;
  lane_seq_pkg::pe_req_t req;
  logic                  req_valid_q;
  logic                  load;

  lane_seq_pkg::vlen_t   vl_quot;
  lane_seq_pkg::vlen_t   vl_rem;
  logic                  extra_elem;
  logic [`LANE_VL_W:0]   mask_sum;

  ////////////////////////////////////////////////////////////////////////////
  // Fall-through register
  ////////////////////////////////////////////////////////////////////////////

  // An empty register lets the incoming request straight through
  assign req            = req_valid_q ? req_q : pe_req_i;
  assign req_valid_o    = req_valid_q | pe_req_valid_i;
  assign pe_req_ready_o = ~req_valid_q | req_ready_i;

  // Capture only what cannot pass through in this cycle
  assign load = pe_req_valid_i & pe_req_ready_o & (req_valid_q | ~req_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (load) begin
      req_valid_q <= 1'b1;
    end else if (req_ready_i) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      req_q <= pe_req_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-lane lengths
  ////////////////////////////////////////////////////////////////////////////

  // Elements are dealt round robin, so the low lanes get the remainder
  assign vl_quot    = req.vl / lane_seq_pkg::vlen_t'(`LANE_NR_LANES);
  assign vl_rem     = req.vl % lane_seq_pkg::vlen_t'(`LANE_NR_LANES);
  assign extra_elem = lane_seq_pkg::vlen_t'(lane_id_i) < vl_rem;

  // One mask word covers ELEN elements in every lane at once
  assign mask_sum = {1'b0, req.vl} +
                    (`LANE_VL_W+1)'(`LANE_NR_LANES * `LANE_ELEN - 1);

  always_comb begin
    lane_req_o.req     = req;
    lane_req_o.lane_vl = vl_quot + lane_seq_pkg::vlen_t'(extra_elem);
    lane_req_o.mask_vl = lane_seq_pkg::vlen_t'(
        mask_sum / (`LANE_VL_W+1)'(`LANE_NR_LANES * `LANE_ELEN));
  end

  // A stalled request must not change under the issuer
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_valid_o && !req_ready_i |=> req_valid_o && $stable(lane_req_o));

endmodule

`default_nettype wire

//--- logic/lane_seq_consts.svh
////////////////////////////////////////////////////////////////////////////
// Lane sequencer constants
// Lane count, datapath widths and operand-queue indices shared by the
// lane sequencer blocks and its testbench
////////////////////////////////////////////////////////////////////////////

`ifndef LANE_SEQ_CONSTS_SVH
`define LANE_SEQ_CONSTS_SVH

// Lanes in the vector unit and instruction IDs in flight
`define LANE_NR_LANES 4
`define LANE_NR_VINSN 8

// Vector length width and element bits held by one mask word
`define LANE_VL_W 16
`define LANE_ELEN 64

// Operand queues served by this sequencer
`define LANE_NR_OPQ 6
`define LANE_OPQ_ALU_A  0
`define LANE_OPQ_ALU_B  1
`define LANE_OPQ_FPU_A  2
`define LANE_OPQ_FPU_B  3
`define LANE_OPQ_FPU_C  4
`define LANE_OPQ_MASK_M 5

`endif

//--- logic/lane_seq_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Lane sequencer types
// Vector typedefs, enums and request/command structs used between the
// main sequencer, the lane sequencer and the operand requester
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "lane_seq_consts.svh"

package lane_seq_pkg;

  typedef logic [$clog2(`LANE_NR_VINSN)-1:0] vinsn_id_t;
  typedef logic [`LANE_NR_VINSN-1:0] vinsn_vec_t;
  typedef logic [4:0] vreg_t;
  typedef logic [`LANE_VL_W-1:0] vlen_t;
  typedef logic [$clog2(`LANE_NR_LANES)-1:0] lane_id_t;
  // Operation code, decoded only inside the VFUs
  typedef logic [5:0] vop_t;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} sew_e;
  typedef enum logic {VFU_ALU, VFU_MFPU} vfu_e;

  // Request from the main sequencer, hazards are one bit per blocking ID
  typedef struct packed {
    vinsn_id_t  id;
    vop_t       op;
    vfu_e       vfu;
    logic       vm;
    logic       use_vs1;
    logic       use_vs2;
    logic       use_vd_op;
    logic       swap_vs2_vd_op;
    vreg_t      vs1;
    vreg_t      vs2;
    vreg_t      vd;
    sew_e       eew_vs1;
    sew_e       eew_vs2;
    sew_e       eew_vd_op;
    sew_e       vsew;
    vlen_t      vl;
    vinsn_vec_t hazard_vs1;
    vinsn_vec_t hazard_vs2;
    vinsn_vec_t hazard_vd;
    vinsn_vec_t hazard_vm;
  } pe_req_t;

  typedef struct packed {
    pe_req_t req;
    vlen_t   lane_vl;
    vlen_t   mask_vl;
  } lane_req_t;

  typedef struct packed {
    vinsn_id_t id;
    vop_t      op;
    vfu_e      vfu;
    logic      vm;
    logic      use_vs1;
    logic      use_vs2;
    logic      use_vd_op;
    logic      swap_vs2_vd_op;
    vreg_t     vd;
    sew_e      vsew;
    vlen_t     vl;
  } vfu_op_t;

  typedef struct packed {
    vinsn_id_t  id;
    vreg_t      vs;
    sew_e       eew;
    vlen_t      vl;
    vinsn_vec_t hazard;
  } opq_cmd_t;

  typedef struct packed {
    vinsn_vec_t vinsn_done;
  } pe_resp_t;

  typedef struct packed {
    logic      valid;
    vinsn_id_t id;
    logic      muted;
  } issue_evt_t;

endpackage

`default_nettype wire

//--- logic/lane_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// Lane sequencer
// Takes vector instructions from the main sequencer, issues them to the
// lane's ALU or multiplier/FPU with their operand requests, and reports
// finished instruction IDs back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lane_seq_consts.svh"

module lane_sequencer (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  lane_seq_pkg::lane_id_t                      lane_id_i,
  // Main sequencer
  input  lane_seq_pkg::pe_req_t                       pe_req_i,
  input  logic                                        pe_req_valid_i,
  output logic                                        pe_req_ready_o,
  input  lane_seq_pkg::vinsn_vec_t                    pe_vinsn_running_i,
  output lane_seq_pkg::pe_resp_t                      pe_resp_o,
  // Operand requester
  output lane_seq_pkg::opq_cmd_t [`LANE_NR_OPQ-1:0]   opq_cmd_o,
  output logic                   [`LANE_NR_OPQ-1:0]   opq_valid_o,
  input  logic                   [`LANE_NR_OPQ-1:0]   opq_ready_i,
  // VFUs
  output lane_seq_pkg::vfu_op_t                       vfu_op_o,
  output logic                                        vfu_op_valid_o,
  input  lane_seq_pkg::vinsn_vec_t                    alu_vinsn_done_i,
  input  lane_seq_pkg::vinsn_vec_t                    mfpu_vinsn_done_i,
  output logic                                        alu_vinsn_done_o,
  output logic                                        mfpu_vinsn_done_o
);

  lane_seq_pkg::lane_req_t  lane_req;
  logic                     req_valid;
  logic                     req_ready;
  lane_seq_pkg::vinsn_vec_t running;
  lane_seq_pkg::issue_evt_t issue_evt;

  lane_req_decoder u_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lane_id_i      (lane_id_i),
    .pe_req_i       (pe_req_i),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_ready_o (pe_req_ready_o),
    .lane_req_o     (lane_req),
    .req_valid_o    (req_valid),
    .req_ready_i    (req_ready)
  );

  operand_cmd_issuer u_issuer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lane_req_i     (lane_req),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .running_i      (running),
    .issue_evt_o    (issue_evt),
    .vfu_op_o       (vfu_op_o),
    .vfu_op_valid_o (vfu_op_valid_o),
    .opq_cmd_o      (opq_cmd_o),
    .opq_valid_o    (opq_valid_o),
    .opq_ready_i    (opq_ready_i)
  );

  vinsn_tracker u_tracker (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .pe_vinsn_running_i (pe_vinsn_running_i),
    .issue_evt_i        (issue_evt),
    .alu_vinsn_done_i   (alu_vinsn_done_i),
    .mfpu_vinsn_done_i  (mfpu_vinsn_done_i),
    .running_o          (running),
    .pe_resp_o          (pe_resp_o),
    .alu_vinsn_done_o   (alu_vinsn_done_o),
    .mfpu_vinsn_done_o  (mfpu_vinsn_done_o)
  );

endmodule

`default_nettype wire

//--- logic/operand_cmd_issuer.sv
////////////////////////////////////////////////////////////////////////////
// Operand command issuer
// Accepts a decoded request when its operand slots are free and its ID is
// not running, then registers the VFU operation and pushes the operand
// request commands into one-deep slots for the operand requester
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lane_seq_consts.svh"

module operand_cmd_issuer (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  lane_seq_pkg::lane_req_t                     lane_req_i,
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  input  lane_seq_pkg::vinsn_vec_t                    running_i,
  output lane_seq_pkg::issue_evt_t                    issue_evt_o,
  output lane_seq_pkg::vfu_op_t                       vfu_op_o,
  output logic                                        vfu_op_valid_o,
  output lane_seq_pkg::opq_cmd_t [`LANE_NR_OPQ-1:0]   opq_cmd_o,
  output logic                   [`LANE_NR_OPQ-1:0]   opq_valid_o,
  input  logic                   [`LANE_NR_OPQ-1:0]   opq_ready_i
);

  lane_seq_pkg::pe_req_t                       req;
  logic                   [`LANE_NR_OPQ-1:0]   need_slot;
  logic                                        accept;
  logic                                        muted;
  lane_seq_pkg::vfu_op_t                       vfu_op_d;
  lane_seq_pkg::opq_cmd_t [`LANE_NR_OPQ-1:0]   opq_cmd_d;
  logic                   [`LANE_NR_OPQ-1:0]   opq_push;

  assign req = lane_req_i.req;

  ////////////////////////////////////////////////////////////////////////////
  // Issue gating
  ////////////////////////////////////////////////////////////////////////////

  // Every unit may need the mask queue on top of its own queues
  always_comb begin
    need_slot                   = '0;
    need_slot[`LANE_OPQ_MASK_M] = 1'b1;
    if (req.vfu == lane_seq_pkg::VFU_ALU) begin
      need_slot[`LANE_OPQ_ALU_A] = 1'b1;
      need_slot[`LANE_OPQ_ALU_B] = 1'b1;
    end else begin
      need_slot[`LANE_OPQ_FPU_A] = 1'b1;
      need_slot[`LANE_OPQ_FPU_B] = 1'b1;
      need_slot[`LANE_OPQ_FPU_C] = 1'b1;
    end
  end

  assign req_ready_o = ((opq_valid_o & need_slot) == '0) && !running_i[req.id];
  assign accept      = req_valid_i && req_ready_o;

  // A lane without elements has nothing to execute, the ID is done at once
  assign muted       = lane_req_i.lane_vl == '0;
  assign issue_evt_o = '{valid: accept, id: req.id, muted: muted};

  assign vfu_op_d = '{
    id:             req.id,
    op:             req.op,
    vfu:            req.vfu,
    vm:             req.vm,
    use_vs1:        req.use_vs1,
    use_vs2:        req.use_vs2,
    use_vd_op:      req.use_vd_op,
    swap_vs2_vd_op: req.swap_vs2_vd_op,
    vd:             req.vd,
    vsew:           req.vsew,
    vl:             lane_req_i.lane_vl
  };

  ////////////////////////////////////////////////////////////////////////////
  // Operand commands
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    opq_cmd_d = '0;
    opq_push  = '0;

    // The mask lives in v0 and is read in whole mask words
    opq_cmd_d[`LANE_OPQ_MASK_M] = '{id: req.id, vs: '0, eew: req.vsew,
        vl: lane_req_i.mask_vl, hazard: req.hazard_vm | req.hazard_vd};
    opq_push[`LANE_OPQ_MASK_M]  = !req.vm;

    if (req.vfu == lane_seq_pkg::VFU_ALU) begin
      opq_cmd_d[`LANE_OPQ_ALU_A] = '{id: req.id, vs: req.vs1, eew: req.eew_vs1,
          vl: lane_req_i.lane_vl, hazard: req.hazard_vs1 | req.hazard_vd};
      opq_push[`LANE_OPQ_ALU_A]  = req.use_vs1;
      opq_cmd_d[`LANE_OPQ_ALU_B] = '{id: req.id, vs: req.vs2, eew: req.eew_vs2,
          vl: lane_req_i.lane_vl, hazard: req.hazard_vs2 | req.hazard_vd};
      opq_push[`LANE_OPQ_ALU_B]  = req.use_vs2;
    end else begin
      opq_cmd_d[`LANE_OPQ_FPU_A] = '{id: req.id, vs: req.vs1, eew: req.eew_vs1,
          vl: lane_req_i.lane_vl, hazard: req.hazard_vs1 | req.hazard_vd};
      opq_push[`LANE_OPQ_FPU_A]  = req.use_vs1;
      // Some fused ops take the accumulator in place of vs2
      if (req.swap_vs2_vd_op) begin
        opq_cmd_d[`LANE_OPQ_FPU_B] = '{id: req.id, vs: req.vd, eew: req.eew_vd_op,
            vl: lane_req_i.lane_vl, hazard: req.hazard_vd};
        opq_push[`LANE_OPQ_FPU_B]  = req.use_vd_op;
        opq_cmd_d[`LANE_OPQ_FPU_C] = '{id: req.id, vs: req.vs2, eew: req.eew_vs2,
            vl: lane_req_i.lane_vl, hazard: req.hazard_vs2 | req.hazard_vd};
        opq_push[`LANE_OPQ_FPU_C]  = req.use_vs2;
      end else begin
        opq_cmd_d[`LANE_OPQ_FPU_B] = '{id: req.id, vs: req.vs2, eew: req.eew_vs2,
            vl: lane_req_i.lane_vl, hazard: req.hazard_vs2 | req.hazard_vd};
        opq_push[`LANE_OPQ_FPU_B]  = req.use_vs2;
        opq_cmd_d[`LANE_OPQ_FPU_C] = '{id: req.id, vs: req.vd, eew: req.eew_vd_op,
            vl: lane_req_i.lane_vl, hazard: req.hazard_vd};
        opq_push[`LANE_OPQ_FPU_C]  = req.use_vd_op;
      end
    end

    if (!accept) begin
      opq_push = '0;
    end
  end

  // Slots and operation pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opq_valid_o    <= '0;
      vfu_op_valid_o <= 1'b0;
    end else begin
      opq_valid_o    <= (opq_valid_o & ~opq_ready_i) | opq_push;
      vfu_op_valid_o <= accept && !muted;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int q = 0; q < `LANE_NR_OPQ; q++) begin
      if (opq_push[q]) begin
        opq_cmd_o[q] <= opq_cmd_d[q];
      end
    end
    if (accept) begin
      vfu_op_o <= vfu_op_d;
    end
  end

  // A full slot is never overwritten, even when it drains in the same cycle
  no_slot_overwrite_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (opq_push & opq_valid_o) == '0);

endmodule

`default_nettype wire

//--- logic/vinsn_tracker.sv
////////////////////////////////////////////////////////////////////////////
// Instruction tracker
// Keeps the set of IDs running in this lane and reports the IDs that the
// VFUs finished, or that had no elements here, to the main sequencer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vinsn_tracker (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  lane_seq_pkg::vinsn_vec_t pe_vinsn_running_i,
  input  lane_seq_pkg::issue_evt_t issue_evt_i,
  input  lane_seq_pkg::vinsn_vec_t alu_vinsn_done_i,
  input  lane_seq_pkg::vinsn_vec_t mfpu_vinsn_done_i,
  output lane_seq_pkg::vinsn_vec_t running_o,
  output lane_seq_pkg::pe_resp_t   pe_resp_o,
  output logic                     alu_vinsn_done_o,
  output logic                     mfpu_vinsn_done_o
);

  lane_seq_pkg::vinsn_vec_t running_q;
  lane_seq_pkg::vinsn_vec_t issue_mask;
  lane_seq_pkg::vinsn_vec_t done_d;

  // IDs the main sequencer has retired drop out of the running set
  assign running_o = running_q & pe_vinsn_running_i;

  assign issue_mask = issue_evt_i.valid ?
                      lane_seq_pkg::vinsn_vec_t'(1) << issue_evt_i.id : '0;

  // Muted issues never reach a VFU, so they finish here
  assign done_d = alu_vinsn_done_i | mfpu_vinsn_done_i |
                  (issue_evt_i.muted ? issue_mask : '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q         <= '0;
      pe_resp_o         <= '0;
      alu_vinsn_done_o  <= 1'b0;
      mfpu_vinsn_done_o <= 1'b0;
    end else begin
      running_q         <= running_o | (issue_evt_i.muted ? '0 : issue_mask);
      pe_resp_o         <= '{vinsn_done: done_d};
      alu_vinsn_done_o  <= |alu_vinsn_done_i;
      mfpu_vinsn_done_o <= |mfpu_vinsn_done_i;
    end
  end

  // The issuer must hold back any ID that is still in flight
  no_reissue_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      issue_evt_i.valid |-> !running_o[issue_evt_i.id]);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the lane sequencer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --assert --timing -Wno-fatal -f compile.f \
  --top-module tb_lane_sequencer -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_lane_sequencer" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
exit 0
